// ==== ipf_pixel_pkg.sv ====
package ipf_pixel_pkg;

    // --------------------
    // image and block geometry
    // --------------------
    localparam int PIXEL_W    = 8;
    localparam int LCU_DIM    = 16;                 // block side in pixels
    localparam int LCU_LAST   = LCU_DIM - 1;        // last row or column of a block
    localparam int LCU_PIXELS = LCU_DIM * LCU_DIM;  // 256
    localparam int IMG_DIM    = 128;                // image side in pixels
    localparam int ADDR_W     = 14;                 // 128 x 128 pixels

    typedef logic [PIXEL_W-1:0] pixel_t;
    typedef logic [3:0]         coord_t;    // row or column inside the block
    typedef logic [2:0]         lcu_pos_t;  // block position in the image
    typedef logic [ADDR_W-1:0]  addr_t;

    // centre pixel with its four neighbours, clamped at the block border
    typedef struct packed {
        pixel_t centre;
        pixel_t left;
        pixel_t right;
        pixel_t up;
        pixel_t down;
        coord_t row;
        coord_t col;
    } pixel_window_t;

endpackage

// ==== ipf_filter_pkg.sv ====
package ipf_filter_pkg;

    // --------------------
    // filter settings
    // --------------------
    localparam int OFFSET_W   = 4;
    localparam int BAND_SHIFT = 3;  // 8 pixel values per band
    localparam int BANDS_USED = 4;  // bands from band_pos that get an offset

    typedef enum logic [1:0] {
        IPF_OFF = 2'd0,
        IPF_PO  = 2'd1,
        IPF_WO  = 2'd2
    } ipf_mode_e;

    typedef enum logic {
        WO_HOR = 1'b0,
        WO_VER = 1'b1
    } wo_class_e;

    typedef logic signed [OFFSET_W-1:0] offset_t;
    typedef logic [4:0]                 band_pos_t;

    typedef struct packed {
        ipf_mode_e                      mode;
        wo_class_e                      wo_class;
        band_pos_t                      band_pos;
        offset_t [BANDS_USED-1:0]       offset;  // element k is offset number k
        ipf_pixel_pkg::lcu_pos_t        lcu_x;
        ipf_pixel_pkg::lcu_pos_t        lcu_y;
    } ipf_cfg_t;

    // result of one classifier, offset is zero when there is no hit
    typedef struct packed {
        logic    hit;
        offset_t offset;
    } offset_pick_t;

    typedef enum logic [1:0] {
        LOAD   = 2'd0,
        FILTER = 2'd1,
        DONE   = 2'd2
    } ctrl_state_e;

endpackage

// ==== lcu_buffer.sv ====
`timescale 1ns/1ps

module lcu_buffer (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         wr_en,
    input  logic [7:0]                   wr_idx,
    input  ipf_pixel_pkg::pixel_t        din,
    input  ipf_pixel_pkg::coord_t        rd_row,
    input  ipf_pixel_pkg::coord_t        rd_col,
    output ipf_pixel_pkg::pixel_window_t window
);

    ipf_pixel_pkg::pixel_t mem [ipf_pixel_pkg::LCU_PIXELS];  // whole block, raster order

    ipf_pixel_pkg::coord_t col_l;
    ipf_pixel_pkg::coord_t col_r;
    ipf_pixel_pkg::coord_t row_u;
    ipf_pixel_pkg::coord_t row_d;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_idx] <= din;
        end
    end

    // neighbour indices, held at the border
    always_comb begin
        col_l = (rd_col == '0) ? rd_col : rd_col - 1'b1;
        col_r = (rd_col == ipf_pixel_pkg::coord_t'(ipf_pixel_pkg::LCU_LAST)) ?
                rd_col : rd_col + 1'b1;
        row_u = (rd_row == '0) ? rd_row : rd_row - 1'b1;
        row_d = (rd_row == ipf_pixel_pkg::coord_t'(ipf_pixel_pkg::LCU_LAST)) ?
                rd_row : rd_row + 1'b1;
    end

    always_comb begin
        window.centre = mem[{rd_row, rd_col}];
        window.left   = mem[{rd_row, col_l}];
        window.right  = mem[{rd_row, col_r}];
        window.up     = mem[{row_u, rd_col}];
        window.down   = mem[{row_d, rd_col}];
        window.row    = rd_row;
        window.col    = rd_col;
    end

    // write index from ctrl must be a known slot of the block
    a_wr_idx_valid: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> !$isunknown(wr_idx) && (int'(wr_idx) < ipf_pixel_pkg::LCU_PIXELS));

endmodule

// ==== ipf_ctrl.sv ====
`timescale 1ns/1ps

module ipf_ctrl (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           in_en,
    input  logic [1:0]                     ipf_type,
    input  logic                           ipf_wo_class,
    input  ipf_filter_pkg::band_pos_t      ipf_band_pos,
    input  logic [15:0]                    ipf_offset,
    input  ipf_pixel_pkg::lcu_pos_t        lcu_x,
    input  ipf_pixel_pkg::lcu_pos_t        lcu_y,
    output logic                           wr_en,
    output logic [7:0]                     wr_idx,
    output ipf_pixel_pkg::coord_t          rd_row,
    output ipf_pixel_pkg::coord_t          rd_col,
    output ipf_filter_pkg::ipf_cfg_t       cfg,
    output logic                           scan_valid,
    output ipf_pixel_pkg::addr_t           scan_addr,
    output logic                           busy,
    output logic                           finish
);

    ipf_filter_pkg::ctrl_state_e state;
    ipf_filter_pkg::ipf_cfg_t    cfg_in;

    logic [7:0] load_cnt;  // pixels accepted so far
    logic [7:0] scan_cnt;  // raster position being filtered
    logic       load_last;
    logic       scan_last;

    // --------------------
    // settings unpack
    // --------------------
    always_comb begin
        cfg_in.mode      = ipf_filter_pkg::ipf_mode_e'(ipf_type);
        cfg_in.wo_class  = ipf_filter_pkg::wo_class_e'(ipf_wo_class);
        cfg_in.band_pos  = ipf_band_pos;
        cfg_in.offset[0] = ipf_offset[15:12];
        cfg_in.offset[1] = ipf_offset[11:8];
        cfg_in.offset[2] = ipf_offset[7:4];
        cfg_in.offset[3] = ipf_offset[3:0];
        cfg_in.lcu_x     = lcu_x;
        cfg_in.lcu_y     = lcu_y;
    end

    assign load_last = (load_cnt == 8'(ipf_pixel_pkg::LCU_PIXELS - 1));
    assign scan_last = (scan_cnt == 8'(ipf_pixel_pkg::LCU_PIXELS - 1));

    // --------------------
    // state machine
    // --------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= ipf_filter_pkg::LOAD;
            load_cnt <= '0;
            scan_cnt <= '0;
            busy     <= 1'b0;
            finish   <= 1'b0;
            cfg      <= '0;
        end else begin
            finish <= 1'b0;
            case (state)
                ipf_filter_pkg::LOAD: begin
                    if (in_en) begin
                        if (load_cnt == '0) begin
                            cfg <= cfg_in;  // settings ride with the first pixel
                        end
                        load_cnt <= load_cnt + 1'b1;  // wraps back to 0 after the block
                        if (load_last) begin
                            state <= ipf_filter_pkg::FILTER;
                            busy  <= 1'b1;
                        end
                    end
                end
                ipf_filter_pkg::FILTER: begin
                    scan_cnt <= scan_cnt + 1'b1;
                    if (scan_last) begin
                        state <= ipf_filter_pkg::DONE;
                    end
                end
                ipf_filter_pkg::DONE: begin
                    // last result leaves the combiner in this cycle
                    state  <= ipf_filter_pkg::LOAD;
                    busy   <= 1'b0;
                    finish <= 1'b1;
                end
                default: begin
                    state <= ipf_filter_pkg::LOAD;
                end
            endcase
        end
    end

    assign wr_en      = in_en && (state == ipf_filter_pkg::LOAD);
    assign wr_idx     = load_cnt;
    assign scan_valid = (state == ipf_filter_pkg::FILTER);
    assign rd_row     = scan_cnt[7:4];
    assign rd_col     = scan_cnt[3:0];

    // image address of the scanned pixel
    assign scan_addr = ipf_pixel_pkg::addr_t'(
        (int'(cfg.lcu_y) * ipf_pixel_pkg::LCU_DIM + int'(rd_row)) * ipf_pixel_pkg::IMG_DIM +
        int'(cfg.lcu_x) * ipf_pixel_pkg::LCU_DIM + int'(rd_col));

    a_no_load_while_busy: assert property (@(posedge clk) disable iff (rst)
        busy |-> !in_en);

    a_finish_pulse: assert property (@(posedge clk) disable iff (rst)
        finish |=> !finish);

endmodule

// ==== band_offset_unit.sv ====
`timescale 1ns/1ps

module band_offset_unit (
    input  ipf_pixel_pkg::pixel_window_t window,
    input  ipf_filter_pkg::ipf_cfg_t     cfg,
    output ipf_filter_pkg::offset_pick_t pick
);

    logic [5:0] band;      // spare top bit so the difference keeps its sign
    logic [5:0] band_rel;  // band relative to band_pos

    always_comb begin
        band     = 6'(window.centre >> ipf_filter_pkg::BAND_SHIFT);
        band_rel = band - {1'b0, cfg.band_pos};
        pick     = '0;

        // only the four bands starting at band_pos are offset
        if (!band_rel[5] && (int'(band_rel) < ipf_filter_pkg::BANDS_USED)) begin
            pick.hit    = 1'b1;
            pick.offset = cfg.offset[band_rel[1:0]];
        end
    end

endmodule

// ==== edge_offset_unit.sv ====
`timescale 1ns/1ps

module edge_offset_unit (
    input  ipf_pixel_pkg::pixel_window_t window,
    input  ipf_filter_pkg::ipf_cfg_t     cfg,
    output ipf_filter_pkg::offset_pick_t pick
);

    ipf_pixel_pkg::pixel_t nb_a;
    ipf_pixel_pkg::pixel_t nb_b;
    logic                  border;
    logic [8:0]            nb_sum;
    logic [8:0]            twice;
    logic [1:0]            cat;
    logic                  cat_hit;

    // --------------------
    // neighbour pair
    // --------------------
    always_comb begin
        if (cfg.wo_class == ipf_filter_pkg::WO_VER) begin
            nb_a   = window.up;
            nb_b   = window.down;
            border = (window.row == '0) ||
                     (window.row == ipf_pixel_pkg::coord_t'(ipf_pixel_pkg::LCU_LAST));
        end else begin
            nb_a   = window.left;
            nb_b   = window.right;
            border = (window.col == '0) ||
                     (window.col == ipf_pixel_pkg::coord_t'(ipf_pixel_pkg::LCU_LAST));
        end
    end

    // --------------------
    // category, first match wins
    // --------------------
    always_comb begin
        nb_sum  = {1'b0, nb_a} + {1'b0, nb_b};
        twice   = {window.centre, 1'b0};
        cat     = 2'd0;
        cat_hit = 1'b0;
        if (!border) begin
            if ((window.centre < nb_a) && (window.centre < nb_b)) begin
                cat     = 2'd0;  // local minimum
                cat_hit = 1'b1;
            end else if ((window.centre > nb_a) && (window.centre > nb_b)) begin
                cat     = 2'd3;  // local maximum
                cat_hit = 1'b1;
            end else if (twice < nb_sum) begin
                cat     = 2'd1;
                cat_hit = 1'b1;
            end else if (twice > nb_sum) begin
                cat     = 2'd2;
                cat_hit = 1'b1;
            end
        end

        pick.hit    = cat_hit;
        pick.offset = cat_hit ? cfg.offset[cat] : '0;
    end

endmodule

// ==== offset_combiner.sv ====
`timescale 1ns/1ps

module offset_combiner (
    input  logic                         clk,
    input  logic                         rst,
    input  ipf_filter_pkg::ipf_cfg_t     cfg,
    input  ipf_pixel_pkg::pixel_window_t window,
    input  ipf_filter_pkg::offset_pick_t band_pick,
    input  ipf_filter_pkg::offset_pick_t edge_pick,
    input  logic                         scan_valid,
    input  ipf_pixel_pkg::addr_t         scan_addr,
    output logic                         out_en,
    output ipf_pixel_pkg::pixel_t        dout,
    output ipf_pixel_pkg::addr_t         dout_addr
);

    ipf_filter_pkg::offset_pick_t pick;
    ipf_filter_pkg::offset_t      sel_off;
    logic signed [9:0]            sum;
    ipf_pixel_pkg::pixel_t        clipped;

    always_comb begin
        case (cfg.mode)
            ipf_filter_pkg::IPF_PO: pick = band_pick;
            ipf_filter_pkg::IPF_WO: pick = edge_pick;
            default:                pick = '0;  // OFF passes the centre through
        endcase
        sel_off = pick.hit ? pick.offset : '0;

        sum = $signed({2'b00, window.centre}) + 10'(sel_off);
        if (sum < 0) begin
            clipped = '0;
        end else if (sum > 10'sd255) begin
            clipped = 8'hff;
        end else begin
            clipped = sum[7:0];
        end
    end

    // --------------------
    // output stage
    // --------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_en <= 1'b0;
        end else begin
            out_en <= scan_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (scan_valid) begin
            dout      <= clipped;
            dout_addr <= scan_addr;
        end
    end

    // mode captured by ctrl must be a legal one for every emitted pixel
    a_mode_legal: assert property (@(posedge clk) disable iff (rst)
        out_en |-> $past(cfg.mode) inside {ipf_filter_pkg::IPF_OFF,
                                           ipf_filter_pkg::IPF_PO,
                                           ipf_filter_pkg::IPF_WO});

endmodule

// ==== ipf.sv ====
`timescale 1ns/1ps

module ipf (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_en,
    input  ipf_pixel_pkg::pixel_t     din,
    input  logic [1:0]                ipf_type,
    input  ipf_filter_pkg::band_pos_t ipf_band_pos,
    input  logic                      ipf_wo_class,
    input  logic [15:0]               ipf_offset,
    input  ipf_pixel_pkg::lcu_pos_t   lcu_x,
    input  ipf_pixel_pkg::lcu_pos_t   lcu_y,
    output logic                      busy,
    output logic                      out_en,
    output ipf_pixel_pkg::pixel_t     dout,
    output ipf_pixel_pkg::addr_t      dout_addr,
    output logic                      finish
);

    logic                         wr_en;
    logic [7:0]                   wr_idx;
    ipf_pixel_pkg::coord_t        rd_row;
    ipf_pixel_pkg::coord_t        rd_col;
    ipf_filter_pkg::ipf_cfg_t     cfg;
    logic                         scan_valid;
    ipf_pixel_pkg::addr_t         scan_addr;
    ipf_pixel_pkg::pixel_window_t window;
    ipf_filter_pkg::offset_pick_t band_pick;
    ipf_filter_pkg::offset_pick_t edge_pick;

    ipf_ctrl i_ctrl (
        .clk          (clk),
        .rst          (rst),
        .in_en        (in_en),
        .ipf_type     (ipf_type),
        .ipf_wo_class (ipf_wo_class),
        .ipf_band_pos (ipf_band_pos),
        .ipf_offset   (ipf_offset),
        .lcu_x        (lcu_x),
        .lcu_y        (lcu_y),
        .wr_en        (wr_en),
        .wr_idx       (wr_idx),
        .rd_row       (rd_row),
        .rd_col       (rd_col),
        .cfg          (cfg),
        .scan_valid   (scan_valid),
        .scan_addr    (scan_addr),
        .busy         (busy),
        .finish       (finish)
    );

    lcu_buffer i_buffer (
        .clk    (clk),
        .rst    (rst),
        .wr_en  (wr_en),
        .wr_idx (wr_idx),
        .din    (din),
        .rd_row (rd_row),
        .rd_col (rd_col),
        .window (window)
    );

    // both classifiers look at the same window
    band_offset_unit i_band (
        .window (window),
        .cfg    (cfg),
        .pick   (band_pick)
    );

    edge_offset_unit i_edge (
        .window (window),
        .cfg    (cfg),
        .pick   (edge_pick)
    );

    offset_combiner i_comb (
        .clk        (clk),
        .rst        (rst),
        .cfg        (cfg),
        .window     (window),
        .band_pick  (band_pick),
        .edge_pick  (edge_pick),
        .scan_valid (scan_valid),
        .scan_addr  (scan_addr),
        .out_en     (out_en),
        .dout       (dout),
        .dout_addr  (dout_addr)
    );

endmodule

// ==== tb_ipf.sv ====
`timescale 1ns/1ps

module tb_ipf;

    localparam int CLK_HALF    = 2;
    localparam int CYCLE_LIMIT = 4000;  // five blocks of about 520 cycles plus margin

    logic                      clk;
    logic                      rst;
    logic                      in_en;
    ipf_pixel_pkg::pixel_t     din;
    logic [1:0]                ipf_type;
    ipf_filter_pkg::band_pos_t ipf_band_pos;
    logic                      ipf_wo_class;
    logic [15:0]               ipf_offset;
    ipf_pixel_pkg::lcu_pos_t   lcu_x;
    ipf_pixel_pkg::lcu_pos_t   lcu_y;
    logic                      busy;
    logic                      out_en;
    logic                      finish;
    ipf_pixel_pkg::pixel_t     dout;
    ipf_pixel_pkg::addr_t      dout_addr;

    ipf_pixel_pkg::pixel_t blk [256];      // block as sent
    ipf_pixel_pkg::pixel_t exp_pix [256];  // expected filtered block
    ipf_pixel_pkg::pixel_t exp_dout;
    ipf_pixel_pkg::addr_t  exp_addr;
    logic [8:0]            out_cnt;
    string                 test_name;
    int                    cycles = 0;
    int edge_pat [16] = '{100, 50, 100, 150, 150, 200, 120, 120,
                          120, 90, 60, 30, 80, 255, 0, 255};  // minima, maxima, slopes, flats

    ipf i_ipf (
        .clk          (clk),
        .rst          (rst),
        .in_en        (in_en),
        .din          (din),
        .ipf_type     (ipf_type),
        .ipf_band_pos (ipf_band_pos),
        .ipf_wo_class (ipf_wo_class),
        .ipf_offset   (ipf_offset),
        .lcu_x        (lcu_x),
        .lcu_y        (lcu_y),
        .busy         (busy),
        .out_en       (out_en),
        .dout         (dout),
        .dout_addr    (dout_addr),
        .finish       (finish)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // --------------------
    // reference rules
    // --------------------
    function automatic int offset_of(int k);
        logic signed [3:0] o;
        o = 4'(ipf_offset >> (12 - 4 * k));  // offset 0 sits in the top nibble
        return int'(o);
    endfunction

    function automatic int pix_at(int r, int c);
        return int'(blk[8'(r * 16 + c)]);
    endfunction

    function automatic ipf_pixel_pkg::pixel_t expected_pixel(int r, int c);
        int p;
        int d;
        int a;
        int b;
        int off;
        bit inner;
        p     = pix_at(r, c);
        off   = 0;
        a     = 0;
        b     = 0;
        inner = 1'b0;
        if (ipf_type == 2'(ipf_filter_pkg::IPF_PO)) begin
            d = p / 8 - int'(ipf_band_pos);
            if (d >= 0 && d <= 3) off = offset_of(d);
        end else if (ipf_type == 2'(ipf_filter_pkg::IPF_WO)) begin
            if (ipf_wo_class && r != 0 && r != 15) begin
                inner = 1'b1;
                a     = pix_at(r - 1, c);
                b     = pix_at(r + 1, c);
            end else if (!ipf_wo_class && c != 0 && c != 15) begin
                inner = 1'b1;
                a     = pix_at(r, c - 1);
                b     = pix_at(r, c + 1);
            end
            // border pixels keep a zero offset
            if (inner) begin
                if (p < a && p < b) off = offset_of(0);
                else if (p > a && p > b) off = offset_of(3);
                else if (2 * p < a + b) off = offset_of(1);
                else if (2 * p > a + b) off = offset_of(2);
            end
        end
        p = p + off;
        if (p < 0) p = 0;
        if (p > 255) p = 255;
        return ipf_pixel_pkg::pixel_t'(p);
    endfunction

    assign exp_dout = exp_pix[out_cnt[7:0]];
    assign exp_addr = ipf_pixel_pkg::addr_t'((int'(lcu_y) * 16 + int'(out_cnt[7:4])) * 128 +
                                             int'(lcu_x) * 16 + int'(out_cnt[3:0]));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_cnt <= '0;
        end else if (finish) begin
            out_cnt <= '0;  // next block starts from pixel 0
        end else if (out_en) begin
            out_cnt <= out_cnt + 1'b1;
        end
    end

    // --------------------
    // failure reports
    // --------------------
    task automatic stop_run();
        $display("RESULT: FAIL");
        $fatal(1, "test stopped");
    endtask

    task automatic report_mismatch(string what, int expv, int actv);
        $display("ERROR %s %s: expected %0d actual %0d", test_name, what, expv, actv);
        stop_run();
    endtask

    task automatic report_failure(string what);
        $display("%s: %s", test_name, what);
        stop_run();
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT) report_failure("timeout, the run took too many cycles");
    end

    a_dout: assert property (@(posedge clk) disable iff (rst) out_en |-> dout == exp_dout)
        else report_mismatch("dout", int'($sampled(exp_dout)), int'($sampled(dout)));

    a_addr: assert property (@(posedge clk) disable iff (rst) out_en |-> dout_addr == exp_addr)
        else report_mismatch("dout_addr", int'($sampled(exp_addr)), int'($sampled(dout_addr)));

    a_count: assert property (@(posedge clk) disable iff (rst) finish |-> out_cnt == 9'd256)
        else report_mismatch("out_en count", 256, int'($sampled(out_cnt)));

    a_idle: assert property (@(posedge clk) $fell(rst) |-> !busy && !out_en && !finish)
        else report_failure("busy, out_en or finish not low after reset");

    a_busy_clear: assert property (@(posedge clk) disable iff (rst) finish |-> !busy && !out_en)
        else report_failure("busy or out_en still high with finish");

    a_out_busy: assert property (@(posedge clk) disable iff (rst) out_en |-> busy)
        else report_failure("out_en seen outside the busy phase");

    a_finish_one: assert property (@(posedge clk) disable iff (rst) finish |=> !finish)
        else report_failure("finish lasted more than one cycle");

    // --------------------
    // stimulus
    // --------------------
    task automatic fill_random(int lo, int span);
        int i;
        for (i = 0; i < 256; i++) begin
            blk[8'(i)] = ipf_pixel_pkg::pixel_t'(lo + int'($urandom % 256) % span);
        end
    endtask

    task automatic fill_edge(bit transpose);
        int r;
        int c;
        for (r = 0; r < 16; r++) begin
            for (c = 0; c < 16; c++) begin
                if (transpose) blk[8'(c * 16 + r)] = 8'(edge_pat[(c + 3 * r) % 16]);
                else blk[8'(r * 16 + c)] = 8'(edge_pat[(c + 3 * r) % 16]);
            end
        end
    endtask

    task automatic run_block(string name, ipf_filter_pkg::ipf_mode_e mode, logic wo_cls,
                             ipf_filter_pkg::band_pos_t bpos, logic [15:0] offs,
                             ipf_pixel_pkg::lcu_pos_t x, ipf_pixel_pkg::lcu_pos_t y, bit gaps);
        int i;
        int gap;
        test_name    = name;
        ipf_type     = mode;
        ipf_wo_class = wo_cls;
        ipf_band_pos = bpos;
        ipf_offset   = offs;
        lcu_x        = x;
        lcu_y        = y;
        for (i = 0; i < 256; i++) exp_pix[8'(i)] = expected_pixel(i / 16, i % 16);
        for (i = 0; i < 256; i++) begin
            if (gaps && ($urandom % 4 == 0)) begin
                in_en = 1'b0;
                gap   = 1 + int'($urandom % 2);
                repeat (gap) begin
                    @(posedge clk);
                    #1;
                end
            end
            in_en = 1'b1;
            din   = blk[8'(i)];
            @(posedge clk);
            #1;
        end
        in_en = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (!finish);  // wait for the block to drain
    endtask

    initial begin
        void'($urandom(1035));
        test_name    = "reset";
        rst          = 1'b1;
        in_en        = 1'b0;
        din          = '0;
        ipf_type     = '0;
        ipf_band_pos = '0;
        ipf_wo_class = 1'b0;
        ipf_offset   = '0;
        lcu_x        = '0;
        lcu_y        = '0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        #1;

        fill_random(0, 256);
        run_block("off_mode", ipf_filter_pkg::IPF_OFF, 1'b0, 5'd0, 16'($urandom),
                  3'd3, 3'd5, 1'b1);
        fill_random(0, 64);  // bands 0..7 with offsets on 0..3 only
        run_block("po_low", ipf_filter_pkg::IPF_PO, 1'b0, 5'd0, 16'h83f7, 3'd1, 3'd2, 1'b0);
        fill_random(192, 64);  // bands 24..31 where the top band clips at 255
        run_block("po_high", ipf_filter_pkg::IPF_PO, 1'b0, 5'd28, 16'h2a57, 3'd6, 3'd1, 1'b0);
        fill_edge(1'b0);
        run_block("wo_hor", ipf_filter_pkg::IPF_WO, 1'b0, 5'd0, 16'hb2d6, 3'd7, 3'd7, 1'b0);
        fill_edge(1'b1);
        run_block("wo_ver", ipf_filter_pkg::IPF_WO, 1'b1, 5'd0, 16'hb2d6, 3'd2, 3'd4, 1'b0);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== ipf.f ====
ipf_pixel_pkg.sv
ipf_filter_pkg.sv
lcu_buffer.sv
ipf_ctrl.sv
band_offset_unit.sv
edge_offset_unit.sv
offset_combiner.sv
ipf.sv
tb_ipf.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the ipf testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_ipf -f ipf.f -o sim_ipf > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/sim_ipf > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation stopped with an error, see sim.log"
    exit 1
fi

if grep -q "RESULT: PASS" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi
